//--- design/icache_pkg.sv
package icache_pkg;

    ////////////////////////////////////////
    // Cache geometry
    ////////////////////////////////////////
    localparam int NUM_LINES  = 16;                     // Lines in the cache
    localparam int LINE_WORDS = 32;                     // 32-bit words per line
    localparam int LINE_IDX_W = $clog2(NUM_LINES);      // Line index, 4 bits
    localparam int WORD_OFS_W = $clog2(LINE_WORDS);     // Word offset, 5 bits
    localparam int TAG_W      = 20;                     // Address bits 26 to 7
    localparam int RAM_AW     = LINE_IDX_W + WORD_OFS_W; // {line, word}, 9 bits

    // Burst length field on the bus
    localparam int BL_W = 10;
    localparam logic [BL_W-1:0] BURST_LEN = BL_W'(LINE_WORDS);

    // CPU access width codes, 3 is illegal
    localparam logic [1:0] WIDTH_BYTE = 2'd0;
    localparam logic [1:0] WIDTH_HALF = 2'd1;
    localparam logic [1:0] WIDTH_WORD = 2'd2;

    ////////////////////////////////////////
    // Controller FSM encoding
    ////////////////////////////////////////
    localparam logic [2:0] ST_IDLE        = 3'd0; // Waiting for a CPU request
    localparam logic [2:0] ST_LOOKUP      = 3'd1; // Tag compare on latched address
    localparam logic [2:0] ST_READ        = 3'd2; // Data RAM read in flight
    localparam logic [2:0] ST_RESP        = 3'd3; // Response strobe on the CPU port
    localparam logic [2:0] ST_WAIT_REFILL = 3'd4; // Line refill in progress

    // CPU address, seen either as a flat bus word or split into cache fields
    typedef union packed {
        logic [31:0] flat;
        struct packed {
            logic [4:0]  unused;   // Above the 128 MB window
            logic [19:0] tag;      // Compared against the tag store
            logic [4:0]  word_ofs; // Word within the line
            logic [1:0]  byte_ofs; // Byte within the word
        } f;
    } icache_addr_u;

endpackage

//--- design/icache_tag_fifo.sv
`timescale 1ns/1ns

module icache_tag_fifo (
    input  logic                              mclk,
    input  logic                              rst_n,
    input  logic [icache_pkg::TAG_W-1:0]      lookup_tag_i,  // Tag under lookup
    output logic                              hit_o,
    output logic [icache_pkg::LINE_IDX_W-1:0] hit_idx_o,     // Line holding the tag
    input  logic                              tag_we_i,      // Fill of the victim line
    input  logic [icache_pkg::TAG_W-1:0]      tag_wtag_i,
    output logic [icache_pkg::LINE_IDX_W-1:0] victim_idx_o   // Next line to replace
);
    import icache_pkg::*;

    logic [TAG_W-1:0]      tag_mem [NUM_LINES]; // Tag per line, qualified by valid
    logic [NUM_LINES-1:0]  valid_q;
    logic [NUM_LINES-1:0]  match;               // One bit per line
    logic [LINE_IDX_W-1:0] fifo_ptr;            // Oldest fill, next to go

    ////////////////////////////////////////
    // Parallel compare
    ////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < NUM_LINES; i++) begin
            match[i] = valid_q[i] && (tag_mem[i] == lookup_tag_i);
        end
    end

    // At most one line matches, so OR-ing the indices encodes it
    always_comb begin
        hit_idx_o = '0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (match[i]) hit_idx_o = hit_idx_o | LINE_IDX_W'(i);
        end
    end

    assign hit_o        = |match;
    assign victim_idx_o = fifo_ptr;

    ////////////////////////////////////////
    // Fill and FIFO pointer
    ////////////////////////////////////////
    always_ff @(posedge mclk) begin
        if (tag_we_i) tag_mem[fifo_ptr] <= tag_wtag_i;
    end

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q  <= '0;                    // All lines invalid after reset
            fifo_ptr <= '0;
        end else if (tag_we_i) begin
            valid_q[fifo_ptr] <= 1'b1;
            fifo_ptr          <= fifo_ptr + 1'b1; // 16 lines, wraps by itself
        end
    end

    // Duplicate tags would make the compare ambiguous
    a_onehot_hit: assert property (@(posedge mclk) disable iff (!rst_n) $onehot0(match))
        else $error("tag store: more than one line hits");

    // Fill only on a missing tag, which then hits at the filled line
    a_fill_miss: assert property (@(posedge mclk) disable iff (!rst_n)
        tag_we_i |-> !hit_o ##1 (hit_o && hit_idx_o == $past(fifo_ptr)))
        else $error("tag store: fill overlaps a lookup in use");

endmodule

//--- design/icache_data_ram.sv
`timescale 1ns/1ns

module icache_data_ram (
    input  logic        mclk,
    input  logic        we_i,     // Refill write port
    input  logic [8:0]  waddr_i,  // {line, word}
    input  logic [31:0] wdata_i,
    input  logic        re_i,     // Lookup read port
    input  logic [8:0]  raddr_i,
    output logic [31:0] rdata_o   // Valid the cycle after re_i
);

    // 16 lines x 32 words
    logic [31:0] mem_q [0:511];

    always_ff @(posedge mclk) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Registered read, holds its value between reads
    always_ff @(posedge mclk) begin
        if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

//--- design/icache_refill.sv
`timescale 1ns/1ns

module icache_refill (
    input  logic                              mclk,
    input  logic                              rst_n,
    input  logic                              refill_start_i, // One-cycle start pulse
    input  icache_pkg::icache_addr_u          refill_addr_i,  // Missing address
    input  logic [icache_pkg::LINE_IDX_W-1:0] victim_idx_i,
    // Burst bus
    output logic                              wb_stb_o,
    output logic [31:0]                       wb_adr_o,
    output logic [icache_pkg::BL_W-1:0]       wb_bl_o,
    input  logic [31:0]                       wb_dat_i,
    input  logic                              wb_ack_i,
    input  logic                              wb_lack_i,
    // Data RAM write port
    output logic                              ram_we_o,
    output logic [icache_pkg::RAM_AW-1:0]     ram_waddr_o,
    output logic [31:0]                       ram_wdata_o,
    // Tag store fill
    output logic                              tag_we_o,
    output logic [icache_pkg::TAG_W-1:0]      tag_wtag_o,
    output logic                              refill_done_o
);
    import icache_pkg::*;

    icache_addr_u          base_q;    // Line base, word and byte offsets zero
    logic [LINE_IDX_W-1:0] victim_q;  // Line being refilled
    logic [WORD_OFS_W-1:0] word_ptr;  // Next word of the burst
    logic                  start_ok;

    assign start_ok = refill_start_i && !wb_stb_o;

    ////////////////////////////////////////
    // Burst sequencing
    ////////////////////////////////////////
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            wb_stb_o      <= 1'b0;
            word_ptr      <= '0;
            refill_done_o <= 1'b0;
        end else begin
            refill_done_o <= 1'b0;                    // Pulse
            if (start_ok) begin
                wb_stb_o <= 1'b1;                     // Busy one cycle after start
                word_ptr <= '0;
            end else if (wb_stb_o && wb_ack_i) begin
                word_ptr <= word_ptr + 1'b1;
                if (wb_lack_i) begin
                    wb_stb_o      <= 1'b0;
                    refill_done_o <= 1'b1;            // Cycle after the tag write
                end
            end
        end
    end

    // Address and victim are captured once per refill
    always_ff @(posedge mclk) begin
        if (start_ok) begin
            base_q            <= refill_addr_i;
            base_q.f.word_ofs <= '0;
            base_q.f.byte_ofs <= '0;
            victim_q          <= victim_idx_i;
        end
    end

    assign wb_adr_o = base_q.flat;
    assign wb_bl_o  = BURST_LEN;

    // Each acked word lands straight in the victim line
    assign ram_we_o    = wb_stb_o && wb_ack_i;
    assign ram_waddr_o = {victim_q, word_ptr};
    assign ram_wdata_o = wb_dat_i;

    assign tag_we_o   = wb_stb_o && wb_ack_i && wb_lack_i; // Tag goes in with the last word
    assign tag_wtag_o = base_q.f.tag;

    // Controller waits for done, so no start lands in a running burst
    a_start_idle: assert property (@(posedge mclk) disable iff (!rst_n)
        refill_start_i |-> !wb_stb_o)
        else $error("refill: start pulse while a burst is running");

    // Last ack marks word 31 and never comes alone
    a_lack_32nd: assert property (@(posedge mclk) disable iff (!rst_n)
        wb_stb_o && (wb_ack_i || wb_lack_i)
            |-> wb_ack_i && (wb_lack_i == (word_ptr == WORD_OFS_W'(LINE_WORDS - 1))))
        else $error("refill: last ack not on the 32nd word");

endmodule

//--- design/icache_ctrl.sv
`timescale 1ns/1ns

module icache_ctrl (
    input  logic                              mclk,
    input  logic                              rst_n,
    // CPU fetch port
    input  logic                              cpu_req_i,
    input  icache_pkg::icache_addr_u          cpu_addr_i,
    input  logic [1:0]                        cpu_width_i,
    output logic                              cpu_req_ack_o,
    output logic [31:0]                       cpu_rdata_o,
    output logic                              cpu_resp_o,   // One-cycle strobe
    // Tag store
    output logic [icache_pkg::TAG_W-1:0]      lookup_tag_o,
    input  logic                              hit_i,
    input  logic [icache_pkg::LINE_IDX_W-1:0] hit_idx_i,
    // Data RAM read port
    output logic                              ram_re_o,
    output logic [icache_pkg::RAM_AW-1:0]     ram_raddr_o,
    input  logic [31:0]                       ram_rdata_i,
    // Refill engine
    output logic                              refill_start_o,
    output icache_pkg::icache_addr_u          refill_addr_o,
    input  logic                              refill_done_i
);
    import icache_pkg::*;

    logic [2:0]   state_q;
    icache_addr_u addr_q;    // Request address, held for the whole access
    logic [1:0]   width_q;

    // Pick the addressed byte or half and right-justify it, upper bits zero
    function automatic logic [31:0] align_rdata(input logic [1:0]  width,
                                                input logic [1:0]  ofs,
                                                input logic [31:0] word);
        logic [31:0] shifted;
        shifted = word >> {ofs, 3'b000};
        case (width)
            WIDTH_BYTE: align_rdata = {24'd0, shifted[7:0]};
            WIDTH_HALF: align_rdata = {16'd0, shifted[15:0]};
            WIDTH_WORD: align_rdata = word;
            default:    align_rdata = '0;
        endcase
    endfunction

    assign cpu_req_ack_o = (state_q == ST_IDLE) && cpu_req_i; // Accept only when idle
    assign lookup_tag_o  = addr_q.f.tag;
    assign refill_addr_o = addr_q;

    // Read issued in the lookup cycle itself, data back one cycle later
    assign ram_re_o    = (state_q == ST_LOOKUP) && hit_i;
    assign ram_raddr_o = {hit_idx_i, addr_q.f.word_ofs};

    ////////////////////////////////////////
    // Controller FSM
    ////////////////////////////////////////
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= ST_IDLE;
            cpu_resp_o     <= 1'b0;
            refill_start_o <= 1'b0;
        end else begin
            cpu_resp_o     <= 1'b0;  // Both are pulses
            refill_start_o <= 1'b0;
            case (state_q)
                ST_IDLE: if (cpu_req_i) state_q <= ST_LOOKUP;
                ST_LOOKUP: begin
                    if (hit_i) begin
                        state_q <= ST_READ;
                    end else begin
                        refill_start_o <= 1'b1;      // Miss, fetch the whole line
                        state_q        <= ST_WAIT_REFILL;
                    end
                end
                ST_READ: begin
                    cpu_resp_o <= 1'b1;
                    state_q    <= ST_RESP;
                end
                ST_RESP: state_q <= ST_IDLE;
                ST_WAIT_REFILL: if (refill_done_i) state_q <= ST_LOOKUP; // Replay as a hit
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge mclk) begin
        if (cpu_req_ack_o) begin
            addr_q  <= cpu_addr_i;
            width_q <= cpu_width_i;
        end
        if (state_q == ST_READ) begin
            cpu_rdata_o <= align_rdata(width_q, addr_q.f.byte_ofs, ram_rdata_i);
        end
    end

    a_width_legal: assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_req_ack_o |-> cpu_width_i != 2'd3)
        else $error("ctrl: illegal width code accepted");

    a_half_align: assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_req_ack_o && cpu_width_i == WIDTH_HALF |-> !cpu_addr_i.f.byte_ofs[0])
        else $error("ctrl: misaligned half-word request");

endmodule

//--- design/icache_top.sv
`timescale 1ns/1ns

module icache_top (
    input  logic                        mclk,
    input  logic                        rst_n,
    // CPU fetch port
    input  logic                        cpu_req_i,
    input  icache_pkg::icache_addr_u    cpu_addr_i,
    input  logic [1:0]                  cpu_width_i,
    output logic                        cpu_req_ack_o,
    output logic [31:0]                 cpu_rdata_o,
    output logic                        cpu_resp_o,
    // Burst read bus
    output logic                        wb_stb_o,
    output logic [31:0]                 wb_adr_o,
    output logic [icache_pkg::BL_W-1:0] wb_bl_o,
    input  logic [31:0]                 wb_dat_i,
    input  logic                        wb_ack_i,
    input  logic                        wb_lack_i
);
    import icache_pkg::*;

    ////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////
    logic [TAG_W-1:0]      lookup_tag;
    logic                  hit;
    logic [LINE_IDX_W-1:0] hit_idx;
    logic [LINE_IDX_W-1:0] victim_idx;
    logic                  tag_we;
    logic [TAG_W-1:0]      tag_wtag;
    logic                  ram_re;     // Lookup side
    logic [RAM_AW-1:0]     ram_raddr;
    logic [31:0]           ram_rdata;
    logic                  ram_we;     // Refill side
    logic [RAM_AW-1:0]     ram_waddr;
    logic [31:0]           ram_wdata;
    logic                  refill_start;
    icache_addr_u          refill_addr;
    logic                  refill_done;

    icache_ctrl u_ctrl (
        .mclk, .rst_n,
        .cpu_req_i, .cpu_addr_i, .cpu_width_i,
        .cpu_req_ack_o, .cpu_rdata_o, .cpu_resp_o,
        .lookup_tag_o (lookup_tag),   .hit_i (hit),           .hit_idx_i (hit_idx),
        .ram_re_o     (ram_re),       .ram_raddr_o (ram_raddr), .ram_rdata_i (ram_rdata),
        .refill_start_o (refill_start), .refill_addr_o (refill_addr),
        .refill_done_i  (refill_done)
    );

    icache_tag_fifo u_tag_fifo (
        .mclk, .rst_n,
        .lookup_tag_i (lookup_tag), .hit_o (hit), .hit_idx_o (hit_idx),
        .tag_we_i (tag_we), .tag_wtag_i (tag_wtag), .victim_idx_o (victim_idx)
    );

    icache_refill u_refill (
        .mclk, .rst_n,
        .refill_start_i (refill_start), .refill_addr_i (refill_addr),
        .victim_idx_i   (victim_idx),
        .wb_stb_o, .wb_adr_o, .wb_bl_o, .wb_dat_i, .wb_ack_i, .wb_lack_i,
        .ram_we_o (ram_we), .ram_waddr_o (ram_waddr), .ram_wdata_o (ram_wdata),
        .tag_we_o (tag_we), .tag_wtag_o (tag_wtag),   .refill_done_o (refill_done)
    );

    // 2 KB line storage
    icache_data_ram u_data_ram (
        .mclk,
        .we_i (ram_we), .waddr_i (ram_waddr), .wdata_i (ram_wdata),
        .re_i (ram_re), .raddr_i (ram_raddr), .rdata_o (ram_rdata)
    );

endmodule

//--- verif/icache_bus_model.sv
`timescale 1ns/1ns

module icache_bus_model (
    input  logic        mclk,
    input  logic        rst_n,
    input  logic        wb_stb_i,    // Burst request from the cache
    input  logic [31:0] wb_adr_i,    // Line base byte address
    input  logic [9:0]  wb_bl_i,     // Words in the burst
    output logic [31:0] wb_dat_o,
    output logic        wb_ack_o,    // One word per ack
    output logic        wb_lack_o    // Comes with the final ack
);

    int beat;   // Words already returned in this burst
    int gap;    // Idle cycles left before the next ack

    // Word address W returns {~W[15:0], W[15:0]}
    function automatic logic [31:0] model_word(input logic [29:0] waddr);
        return {~waddr[15:0], waddr[15:0]};
    endfunction

    ////////////////////////////////////////
    // Responder, outputs move on falling edges
    ////////////////////////////////////////
    initial begin
        wb_dat_o  = '0;
        wb_ack_o  = 1'b0;
        wb_lack_o = 1'b0;
        beat      = 0;
        gap       = 0;
        forever begin
            @(negedge mclk);
            wb_ack_o  = 1'b0;
            wb_lack_o = 1'b0;
            if (!rst_n || !wb_stb_i) begin
                beat = 0;                          // Idle bus, next burst starts fresh
                gap  = $urandom_range(3, 0);
            end else if (gap != 0) begin
                gap = gap - 1;                     // Random stall between words
            end else begin
                wb_dat_o  = model_word(wb_adr_i[31:2] + 30'(beat));
                wb_ack_o  = 1'b1;
                wb_lack_o = (beat == int'(wb_bl_i) - 1);
                beat      = beat + 1;
                gap       = $urandom_range(3, 0);
            end
        end
    end

endmodule

//--- verif/tb_icache.sv
`timescale 1ns/1ns

module tb_icache;
    import icache_pkg::*;

    localparam int ACCEPT_LIMIT = 20;   // Cycles until a request must be taken
    localparam int RESP_LIMIT   = 400;  // Covers a full burst with worst ack gaps

    logic            mclk = 1'b0;
    logic            rst_n;
    logic            cpu_req_i;
    icache_addr_u    cpu_addr_i;
    logic [1:0]      cpu_width_i;
    logic            cpu_req_ack_o;
    logic [31:0]     cpu_rdata_o;
    logic            cpu_resp_o;
    logic            wb_stb_o;
    logic [31:0]     wb_adr_o;
    logic [BL_W-1:0] wb_bl_o;
    logic [31:0]     wb_dat_i;
    logic            wb_ack_i;
    logic            wb_lack_i;

    // Expected results of the request in flight
    logic [31:0]          exp_rdata;
    logic [31:0]          exp_base;    // Line base the burst must use
    logic                 exp_hit;
    // Resident lines, replaced oldest first
    logic [TAG_W-1:0]     res_tag [NUM_LINES];
    logic [NUM_LINES-1:0] res_valid;
    int                   res_ptr;
    logic [TAG_W-1:0]     line_tag [17];
    logic                 accept;
    logic                 busy;        // Accepted and not yet answered
    int                   burst_cnt;   // Bursts finished for this request
    int                   ack_cnt;     // Acks so far in the current burst

    always #20 mclk = ~mclk;

    icache_top i_icache_top (
        .mclk, .rst_n,
        .cpu_req_i, .cpu_addr_i, .cpu_width_i, .cpu_req_ack_o, .cpu_rdata_o, .cpu_resp_o,
        .wb_stb_o, .wb_adr_o, .wb_bl_o, .wb_dat_i, .wb_ack_i, .wb_lack_i
    );

    icache_bus_model u_bus_model (
        .mclk, .rst_n,
        .wb_stb_i (wb_stb_o), .wb_adr_i (wb_adr_o), .wb_bl_i (wb_bl_o),
        .wb_dat_o (wb_dat_i), .wb_ack_o (wb_ack_i), .wb_lack_o (wb_lack_i)
    );

    task automatic value_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "wrong value seen");
    endtask

    task automatic hang_error(input string msg);
        $display("Timeout at %0t ns, %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation hung");
    endtask

    // Memory word behind a byte address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [15:0] w;
        w = addr[17:2];
        return {~w, w};
    endfunction

    function automatic logic [31:0] expected_rdata(input logic [31:0] addr,
                                                   input logic [1:0]  width);
        logic [31:0] word;
        word = mem_word(addr);
        case (width)
            WIDTH_BYTE: return 32'(word[addr[1:0]*8 +: 8]);   // Zero upper bits
            WIDTH_HALF: return 32'(word[addr[1]*16 +: 16]);
            default:    return word;
        endcase
    endfunction

    // Hit if resident, else the miss takes the oldest slot
    task automatic predict_lookup(input logic [TAG_W-1:0] tag, output logic hit);
        hit = 1'b0;
        for (int i = 0; i < NUM_LINES; i++) begin
            if (res_valid[i] && res_tag[i] == tag) hit = 1'b1;
        end
        if (!hit) begin
            res_tag[res_ptr]   = tag;
            res_valid[res_ptr] = 1'b1;
            res_ptr            = (res_ptr + 1) % NUM_LINES;
        end
    endtask

    task automatic wait_accept();
        int cnt;
        cnt = 0;
        while (!busy && cnt < ACCEPT_LIMIT) begin
            @(negedge mclk);
            cnt++;
        end
        if (!busy) hang_error("the cache never accepted the request");
    endtask

    task automatic wait_resp();
        int cnt;
        cnt = 0;
        while (!cpu_resp_o && cnt < RESP_LIMIT) begin
            @(negedge mclk);
            cnt++;
        end
        if (!cpu_resp_o) hang_error("no response came back from the cache");
    endtask

    task automatic access(input logic [31:0] addr, input logic [1:0] width);
        logic hit;
        @(negedge mclk);
        predict_lookup(addr[26:7], hit);
        exp_hit         = hit;
        exp_rdata       = expected_rdata(addr, width);
        exp_base        = {addr[31:7], 7'd0};
        cpu_addr_i.flat = addr;
        cpu_width_i     = width;
        cpu_req_i       = 1'b1;    // Held until the response
        wait_accept();
        wait_resp();
        cpu_req_i       = 1'b0;
    endtask

    // Random word of a line, legal width and offset
    task automatic random_access(input logic [TAG_W-1:0] tag);
        logic [1:0] width;
        logic [1:0] ofs;
        width = 2'($urandom_range(2, 0));
        ofs   = 2'($urandom_range(3, 0));
        if (width == WIDTH_HALF) ofs[0] = 1'b0;
        if (width == WIDTH_WORD) ofs = 2'd0;
        access({5'd0, tag, 5'($urandom_range(31, 0)), ofs}, width);
    endtask

    task automatic apply_reset();
        @(negedge mclk);
        rst_n     = 1'b0;
        res_valid = '0;           // Cache forgets every line
        res_ptr   = 0;
        repeat (3) @(negedge mclk);
        rst_n     = 1'b1;
    endtask

    ////////////////////////////////////////
    // Request and burst tracking
    ////////////////////////////////////////
    assign accept = cpu_req_i && cpu_req_ack_o;

    always @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            burst_cnt <= 0;
            ack_cnt   <= 0;
        end else begin
            if (accept) busy <= 1'b1;
            else if (cpu_resp_o) busy <= 1'b0;
            if (accept) burst_cnt <= 0;
            else if (wb_stb_o && wb_ack_i && wb_lack_i) burst_cnt <= burst_cnt + 1;
            if (wb_stb_o && wb_ack_i) ack_cnt <= wb_lack_i ? 0 : ack_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////
    a_rdata: assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_resp_o |-> cpu_rdata_o == exp_rdata)
        else value_error("read data differs from the aligned memory word");

    a_burst_cnt: assert property (@(posedge mclk) disable iff (!rst_n)
        cpu_resp_o |-> burst_cnt == (exp_hit ? 0 : 1))
        else value_error("wrong number of bursts for the request");

    a_hit_time: assert property (@(posedge mclk) disable iff (!rst_n)
        accept && exp_hit |-> ##1 !cpu_resp_o ##1 !cpu_resp_o ##1 cpu_resp_o)
        else value_error("hit response not three cycles after accept");

    a_hit_quiet: assert property (@(posedge mclk) disable iff (!rst_n)
        busy && exp_hit |-> !wb_stb_o)
        else value_error("bus strobe raised on a hit");

    // Strobe high in the third cycle after accept
    a_miss_stb: assert property (@(posedge mclk) disable iff (!rst_n)
        accept && !exp_hit |-> ##1 !wb_stb_o ##1 !wb_stb_o ##1 wb_stb_o)
        else value_error("miss did not start a burst on time");

    a_burst_adr: assert property (@(posedge mclk) disable iff (!rst_n)
        wb_stb_o |-> wb_adr_o == exp_base && wb_bl_o == BURST_LEN)
        else value_error("burst address or length wrong");

    a_stb_hold: assert property (@(posedge mclk) disable iff (!rst_n)
        wb_stb_o && !(wb_ack_i && wb_lack_i) |=> wb_stb_o && $stable(wb_adr_o))
        else value_error("burst dropped before the last ack");

    a_lack_32: assert property (@(posedge mclk) disable iff (!rst_n)
        wb_stb_o && wb_ack_i && wb_lack_i |-> ack_cnt == LINE_WORDS - 1)
        else value_error("last ack not on the 32nd word");

    // Done one cycle after the last ack, response three after that
    a_refill_resp: assert property (@(posedge mclk) disable iff (!rst_n)
        wb_stb_o && wb_ack_i && wb_lack_i
            |-> ##1 !cpu_resp_o ##1 !cpu_resp_o ##1 !cpu_resp_o ##1 cpu_resp_o)
        else value_error("miss response not on time after refill");

    a_ack_low: assert property (@(posedge mclk) disable iff (!rst_n)
        busy |-> !cpu_req_ack_o)
        else value_error("request ack high while a request is pending");

    a_reset_quiet: assert property (@(posedge mclk) !rst_n |-> !cpu_resp_o && !wb_stb_o)
        else value_error("response or strobe active during reset");

    a_reset_exit: assert property (@(posedge mclk) $rose(rst_n) |-> !cpu_resp_o && !wb_stb_o)
        else value_error("response or strobe active right after reset");

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        logic [TAG_W-1:0] tag_a;
        void'($urandom(50));
        rst_n       = 1'b0;
        cpu_req_i   = 1'b0;
        cpu_addr_i  = '0;
        cpu_width_i = WIDTH_WORD;
        exp_rdata   = '0;
        exp_base    = '0;
        exp_hit     = 1'b0;
        res_valid   = '0;
        res_ptr     = 0;
        repeat (3) @(negedge mclk);
        rst_n = 1'b1;

        // All widths and offsets on one line, first one misses
        tag_a = TAG_W'($urandom);
        for (int ofs = 0; ofs < 4; ofs++) begin
            access({5'd0, tag_a, 5'd3, 2'(ofs)}, WIDTH_BYTE);
        end
        access({5'd0, tag_a, 5'd17, 2'd0}, WIDTH_HALF);
        access({5'd0, tag_a, 5'd17, 2'd2}, WIDTH_HALF);
        access({5'd0, tag_a, 5'd31, 2'd0}, WIDTH_WORD);
        access({5'd0, tag_a, 5'd0, 2'd0}, WIDTH_WORD);

        apply_reset();   // Resident line is gone now

        // 17 distinct lines, tag_a first
        for (int i = 0; i < 17; i++) begin
            line_tag[i] = tag_a ^ TAG_W'(i * 'h9e37);
            random_access(line_tag[i]);
        end
        random_access(line_tag[16]);   // Newest, hits
        random_access(line_tag[0]);    // Pushed out by the 17th fill
        random_access(line_tag[1]);    // Pushed out by the refill above
        for (int n = 0; n < 40; n++) begin
            random_access(line_tag[$urandom_range(16, 0)]);
        end

        repeat (2) @(negedge mclk);
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- icache_top.f
design/icache_pkg.sv
design/icache_tag_fifo.sv
design/icache_data_ram.sv
design/icache_refill.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_bus_model.sv
verif/tb_icache.sv

//--- Makefile
SRCS = $(wildcard design/*.sv verif/*.sv)

.PHONY: all lint clean

all: obj_dir/Vtb_icache
	./obj_dir/Vtb_icache

obj_dir/Vtb_icache: icache_top.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_icache -f icache_top.f

lint:
	verilator --lint-only --timing -Wall --top-module icache_top -f icache_top.f

clean:
	rm -rf obj_dir
